/* dispatch.f */
hdl/dispatchPkg.sv
hdl/renameDispatchReg.sv
hdl/dispatchSpaceCheck.sv
hdl/dispatchPacketBuild.sv
hdl/dispatchTop.sv
testbench/dispatch_assertions.sv
testbench/dispatchTb.sv

/* hdl/dispatchPacketBuild.sv */
//////////////////////////////
// Purely combinational, one verified branch per cycle
//////////////////////////////

`timescale 1ns/100ps

module dispatchPacketBuild import dispatchPkg::*; (
  input  renamedBundle_t                    heldBundle_i,
  input  ctrlVerify_t                       ctrlVerify_i,
  output renamedBundle_t                    updatedBundle_o,
  output issueqEntry_t [DISPATCH_WIDTH-1:0] issueqPacket_o,
  output alEntry_t     [DISPATCH_WIDTH-1:0] alPacket_o,
  output lsqEntry_t    [DISPATCH_WIDTH-1:0] lsqPacket_o
);

  always_comb begin : buildPackets
    renamedInst_t inst;
    logic         isLoad;
    logic         isStore;

    updatedBundle_o.valid = heldBundle_i.valid;

    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      inst = heldBundle_i.inst[lane];

      // A correctly resolved branch no longer guards younger instructions
      if (ctrlVerify_i.valid) begin
        inst.branchMask[ctrlVerify_i.tag] = 1'b0;
      end
      updatedBundle_o.inst[lane] = inst;

      isLoad  = (inst.memKind == MEM_LOAD);
      isStore = (inst.memKind == MEM_STORE);

      // Issue queue needs the operand tags and the dependence mask
      issueqPacket_o[lane].phyDest    = inst.phyDest;
      issueqPacket_o[lane].phySrc1    = inst.phySrc1;
      issueqPacket_o[lane].phySrc2    = inst.phySrc2;
      issueqPacket_o[lane].destValid  = inst.destValid;
      issueqPacket_o[lane].memKind    = inst.memKind;
      issueqPacket_o[lane].branchMask = inst.branchMask;

      // Active list keeps what retirement and the rename map need
      alPacket_o[lane].isLoad  = isLoad;
      alPacket_o[lane].isStore = isStore;
      alPacket_o[lane].pc      = inst.pc;
      alPacket_o[lane].logDest = inst.logDest;
      alPacket_o[lane].phyDest = inst.phyDest;

      lsqPacket_o[lane].branchMask = inst.branchMask;
      lsqPacket_o[lane].isStore    = isStore;
      lsqPacket_o[lane].isLoad     = isLoad;
    end
  end

endmodule

/* hdl/dispatchPkg.sv */
//////////////////////////////
// Sizes fixed for a four-wide core with eight branch checkpoints
// Queue counts carry one extra bit so a full queue is representable
//////////////////////////////

package dispatchPkg;

  // Machine width and branch checkpoints
  localparam int DISPATCH_WIDTH      = 4;
  localparam int CHECKPOINTS         = 8;
  localparam int CHECKPOINTS_LOG     = 3;

  // Register and PC widths
  localparam int SIZE_PHYSICAL_LOG   = 6;
  localparam int SIZE_RMT_LOG        = 5;
  localparam int SIZE_PC             = 32;

  // Back-end capacities
  localparam int SIZE_LSQ            = 16;
  localparam int SIZE_LSQ_LOG        = 4;
  localparam int SIZE_ISSUEQ         = 32;
  localparam int SIZE_ISSUEQ_LOG     = 5;
  localparam int SIZE_ACTIVELIST     = 64;
  localparam int SIZE_ACTIVELIST_LOG = 6;

  // Memory class of an instruction, used for the LSQ flags
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } memKind_t;

  // One instruction as it leaves rename
  typedef struct packed {
    logic [SIZE_PC-1:0]           pc;
    logic [SIZE_RMT_LOG-1:0]      logDest;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic                         destValid;
    memKind_t                     memKind;
    logic [CHECKPOINTS-1:0]       branchMask;
  } renamedInst_t;

  // Lane 0 is the oldest instruction of the bundle
  typedef struct packed {
    renamedInst_t [DISPATCH_WIDTH-1:0] inst;
    logic                              valid;
  } renamedBundle_t;

  typedef struct packed {
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic                         destValid;
    memKind_t                     memKind;
    logic [CHECKPOINTS-1:0]       branchMask;
  } issueqEntry_t;

  typedef struct packed {
    logic                         isLoad;
    logic                         isStore;
    logic [SIZE_PC-1:0]           pc;
    logic [SIZE_RMT_LOG-1:0]      logDest;
    logic [SIZE_PHYSICAL_LOG-1:0] phyDest;
  } alEntry_t;

  typedef struct packed {
    logic [CHECKPOINTS-1:0] branchMask;
    logic                   isStore;
    logic                   isLoad;
  } lsqEntry_t;

  // Current occupancy of each back-end structure
  typedef struct packed {
    logic [SIZE_LSQ_LOG:0]        loadQueueCnt;
    logic [SIZE_LSQ_LOG:0]        storeQueueCnt;
    logic [SIZE_ISSUEQ_LOG:0]     issueQueueCnt;
    logic [SIZE_ACTIVELIST_LOG:0] activeListCnt;
  } queueCounts_t;

  // A branch that resolved correctly and frees its checkpoint
  typedef struct packed {
    logic                       valid;
    logic [CHECKPOINTS_LOG-1:0] tag;
  } ctrlVerify_t;

endpackage

/* hdl/dispatchSpaceCheck.sv */
//////////////////////////////
// Every bundle reserves four IQ and AL slots whatever its lane mix
// An invalid bundle reserves no LSQ entries
//////////////////////////////

`timescale 1ns/100ps

module dispatchSpaceCheck import dispatchPkg::*; (
  input  renamedBundle_t heldBundle_i,
  input  queueCounts_t   queueCounts_i,
  input  logic           flagRecoverEX_i,
  output logic           stallFrontEnd_o,
  output logic           backEndReady_o
);

  logic [2:0] loadCnt;
  logic [2:0] storeCnt;
  logic       lqFull;
  logic       sqFull;
  logic       iqFull;
  logic       alFull;

  // Count the memory instructions of the held bundle
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      if (heldBundle_i.valid) begin
        loadCnt  = loadCnt + {2'b00, heldBundle_i.inst[lane].memKind == MEM_LOAD};
        storeCnt = storeCnt + {2'b00, heldBundle_i.inst[lane].memKind == MEM_STORE};
      end
    end
  end

  assign lqFull = (32'(queueCounts_i.loadQueueCnt) + 32'(loadCnt)) > SIZE_LSQ;
  assign sqFull = (32'(queueCounts_i.storeQueueCnt) + 32'(storeCnt)) > SIZE_LSQ;
  assign iqFull = (32'(queueCounts_i.issueQueueCnt) + DISPATCH_WIDTH) > SIZE_ISSUEQ;
  assign alFull = (32'(queueCounts_i.activeListCnt) + DISPATCH_WIDTH) > SIZE_ACTIVELIST;

  assign stallFrontEnd_o = lqFull | sqFull | iqFull | alFull;

  // The back end takes the bundle only when it is valid, fits, and survives recovery
  assign backEndReady_o = heldBundle_i.valid & ~stallFrontEnd_o & ~flagRecoverEX_i;

endmodule

/* hdl/dispatchTop.sv */
//////////////////////////////
// Packets are valid only while backEndReady_o is high
// Front end must hold its bundle while stallFrontEnd_o is high
//////////////////////////////

`timescale 1ns/100ps

module dispatchTop import dispatchPkg::*; (
  input  logic                                         clk,
  input  logic                                         rstN_i,
  input  logic                                         renameReady_i,
  input  logic                                         flagRecoverEX_i,
  input  renamedBundle_t                               renamedBundle_i,
  input  queueCounts_t                                 queueCounts_i,
  input  ctrlVerify_t                                  ctrlVerify_i,
  output issueqEntry_t [DISPATCH_WIDTH-1:0]            issueqPacket_o,
  output alEntry_t     [DISPATCH_WIDTH-1:0]            alPacket_o,
  output lsqEntry_t    [DISPATCH_WIDTH-1:0]            lsqPacket_o,
  output logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0]   updatedBranchMask_o,
  output logic                                         backEndReady_o,
  output logic                                         stallFrontEnd_o
);

  renamedBundle_t heldBundle;
  renamedBundle_t updatedBundle;

  renameDispatchReg u_reg (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .stallFrontEnd_i (stallFrontEnd_o),
    .renamedBundle_i (renamedBundle_i),
    .updatedBundle_i (updatedBundle),
    .heldBundle_o    (heldBundle)
  );

  dispatchSpaceCheck u_space (
    .heldBundle_i    (heldBundle),
    .queueCounts_i   (queueCounts_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .stallFrontEnd_o (stallFrontEnd_o),
    .backEndReady_o  (backEndReady_o)
  );

  dispatchPacketBuild u_build (
    .heldBundle_i    (heldBundle),
    .ctrlVerify_i    (ctrlVerify_i),
    .updatedBundle_o (updatedBundle),
    .issueqPacket_o  (issueqPacket_o),
    .alPacket_o      (alPacket_o),
    .lsqPacket_o     (lsqPacket_o)
  );

  // Masks fed back to rename so a stalled bundle stays consistent
  for (genvar lane = 0; lane < DISPATCH_WIDTH; lane++) begin : genMask
    assign updatedBranchMask_o[lane] = updatedBundle.inst[lane].branchMask;
  end

endmodule

/* hdl/renameDispatchReg.sv */
//////////////////////////////
// Payload has no reset, only the bundle valid bit is cleared
//////////////////////////////

`timescale 1ns/100ps

module renameDispatchReg import dispatchPkg::*; (
  input  logic           clk,
  input  logic           rstN_i,
  input  logic           renameReady_i,
  input  logic           flagRecoverEX_i,
  input  logic           stallFrontEnd_i,
  input  renamedBundle_t renamedBundle_i,
  input  renamedBundle_t updatedBundle_i,
  output renamedBundle_t heldBundle_o
);

  always_ff @(posedge clk) begin
    if (stallFrontEnd_i) begin
      // Hold the bundle but keep any mask bit freed by a verified branch
      heldBundle_o <= updatedBundle_i;
    end else begin
      heldBundle_o.inst  <= renamedBundle_i.inst;
      heldBundle_o.valid <= renameReady_i;
    end

    // Recovery squashes whatever sits between rename and dispatch
    if (!rstN_i || flagRecoverEX_i) begin
      heldBundle_o.valid <= 1'b0;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the dispatch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wall -Wno-fatal \
  -f dispatch.f \
  --top-module dispatchTb \
  -o simv

# The simulation result is judged from the log, not from the exit status
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
fi
exit 1

/* testbench/dispatchTb.sv */
//////////////////////////////
// Outputs are sampled on the falling edge, inputs change on the rising edge
//////////////////////////////

`timescale 1ns/100ps

module dispatchTb import dispatchPkg::*; ();

  localparam int          NUM_ROWS  = 12;
  localparam int          MAX_CYCLE = 12 * NUM_ROWS + 50;
  localparam logic [31:0] SEED      = 32'hd9c514c7;

  typedef struct packed {
    logic [3:0][1:0] kinds;
    logic [3:0][7:0] masks;
    logic [31:0]     pcSeed;
    queueCounts_t    counts;
    ctrlVerify_t     verify;
    logic            expReady;
    logic            expStall;
    logic [2:0]      expLoads;
    logic [2:0]      expStores;
  } row_t;

  logic           clk;
  logic           rstN_i;
  logic           renameReady_i;
  logic           flagRecoverEX_i;
  renamedBundle_t renamedBundle_i;
  queueCounts_t   queueCounts_i;
  ctrlVerify_t    ctrlVerify_i;
  issueqEntry_t [DISPATCH_WIDTH-1:0]          issueqPacket_o;
  alEntry_t     [DISPATCH_WIDTH-1:0]          alPacket_o;
  lsqEntry_t    [DISPATCH_WIDTH-1:0]          lsqPacket_o;
  logic [DISPATCH_WIDTH-1:0][CHECKPOINTS-1:0] updatedBranchMask_o;
  logic           backEndReady_o;
  logic           stallFrontEnd_o;

  row_t           rows [NUM_ROWS];
  logic [31:0]    rngState;
  int             errors;
  int             cycles = 0;
  renamedBundle_t bundleA;
  renamedBundle_t bundleB;
  ctrlVerify_t    noVerify;
  ctrlVerify_t    verifyTag2;

  dispatchTop u_dut (.*);

  bind dispatchTop dispatchAssertions u_assert (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .backEndReady  (backEndReady_o),
    .stall         (stallFrontEnd_o),
    .heldBundle    (heldBundle)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic row_t makeRow(input logic [7:0] kinds, input logic [31:0] masks,
      input logic [31:0] pcSeed, input int lq, input int sq, input int iq, input int al,
      input logic vValid, input int vTag, input logic rdy, input logic stl,
      input int lds, input int sts);
    row_t r;
    r.kinds    = kinds;
    r.masks    = masks;
    r.pcSeed   = pcSeed;
    r.counts   = '{loadQueueCnt: 5'(lq), storeQueueCnt: 5'(sq),
                   issueQueueCnt: 6'(iq), activeListCnt: 7'(al)};
    r.verify   = '{valid: vValid, tag: 3'(vTag)};
    r.expReady = rdy;
    r.expStall = stl;
    r.expLoads = 3'(lds);
    r.expStores = 3'(sts);
    return r;
  endfunction

  // Random register fields, repeatable per row through the pc seed
  function automatic renamedBundle_t buildBundle(input row_t r);
    renamedBundle_t b;
    b.valid = 1'b1;
    rngState = SEED ^ r.pcSeed;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      rngState = xorshift32(rngState);
      b.inst[lane].pc = rngState;
      rngState = xorshift32(rngState);
      b.inst[lane].logDest    = rngState[4:0];
      b.inst[lane].phyDest    = rngState[10:5];
      b.inst[lane].phySrc1    = rngState[16:11];
      b.inst[lane].phySrc2    = rngState[22:17];
      b.inst[lane].destValid  = rngState[23];
      b.inst[lane].memKind    = memKind_t'(r.kinds[lane]);
      b.inst[lane].branchMask = r.masks[lane];
    end
    return b;
  endfunction

  task automatic reportError(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic checkOutputs(input renamedBundle_t exp, input ctrlVerify_t v,
      input logic expReady, input logic expStall, input int expLoads, input int expStores,
      input string name);
    logic [CHECKPOINTS-1:0] expMask;
    int loads;
    int stores;
    loads  = 0;
    stores = 0;
    assert (backEndReady_o == expReady)
      else reportError($sformatf("%s backEndReady_o %b expected %b", name,
                                 backEndReady_o, expReady));
    assert (stallFrontEnd_o == expStall)
      else reportError($sformatf("%s stallFrontEnd_o %b expected %b", name,
                                 stallFrontEnd_o, expStall));
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      expMask = exp.inst[lane].branchMask;
      if (v.valid) expMask[v.tag] = 1'b0;
      assert (issueqPacket_o[lane].branchMask == expMask &&
              lsqPacket_o[lane].branchMask == expMask &&
              updatedBranchMask_o[lane] == expMask)
        else reportError($sformatf("%s lane %0d mask expected %h", name, lane, expMask));
      assert (issueqPacket_o[lane].phyDest == exp.inst[lane].phyDest &&
              issueqPacket_o[lane].phySrc1 == exp.inst[lane].phySrc1 &&
              issueqPacket_o[lane].phySrc2 == exp.inst[lane].phySrc2 &&
              issueqPacket_o[lane].destValid == exp.inst[lane].destValid &&
              issueqPacket_o[lane].memKind == exp.inst[lane].memKind)
        else reportError($sformatf("%s lane %0d issue-queue fields wrong", name, lane));
      assert (alPacket_o[lane].pc == exp.inst[lane].pc &&
              alPacket_o[lane].logDest == exp.inst[lane].logDest &&
              alPacket_o[lane].phyDest == exp.inst[lane].phyDest)
        else reportError($sformatf("%s lane %0d active-list fields wrong", name, lane));
      assert (alPacket_o[lane].isLoad == (exp.inst[lane].memKind == MEM_LOAD) &&
              alPacket_o[lane].isStore == (exp.inst[lane].memKind == MEM_STORE) &&
              lsqPacket_o[lane].isLoad == (exp.inst[lane].memKind == MEM_LOAD) &&
              lsqPacket_o[lane].isStore == (exp.inst[lane].memKind == MEM_STORE))
        else reportError($sformatf("%s lane %0d load/store flags wrong", name, lane));
      loads  += int'(lsqPacket_o[lane].isLoad);
      stores += int'(lsqPacket_o[lane].isStore);
    end
    assert (loads == expLoads && stores == expStores)
      else reportError($sformatf("%s loads %0d stores %0d expected %0d %0d", name,
                                 loads, stores, expLoads, expStores));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLE) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    clk             = 1'b0;
    rstN_i          <= 1'b0;
    renameReady_i   <= 1'b0;
    flagRecoverEX_i <= 1'b0;
    renamedBundle_i <= '0;
    queueCounts_i   <= '0;
    ctrlVerify_i    <= '0;
    errors          = 0;
    noVerify        = '0;
    verifyTag2      = '{valid: 1'b1, tag: 3'd2};

    // kinds lane3..lane0, masks lane3..lane0, seed, lq sq iq al, verify, expected
    rows[0]  = makeRow({MEM_NONE, MEM_NONE, MEM_NONE, MEM_NONE}, 32'h01020408, 32'h11,
                       0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
    rows[1]  = makeRow({MEM_STORE, MEM_STORE, MEM_STORE, MEM_NONE}, 32'h0, 32'h22,
                       0, 14, 0, 0, 0, 0, 0, 1, 0, 3);
    rows[2]  = makeRow({MEM_NONE, MEM_STORE, MEM_NONE, MEM_LOAD}, 32'hff, 32'h33,
                       0, 15, 0, 0, 0, 0, 1, 0, 1, 1);
    rows[3]  = makeRow({MEM_STORE, MEM_NONE, MEM_STORE, MEM_NONE}, 32'h0, 32'h44,
                       0, 15, 0, 0, 0, 0, 0, 1, 0, 2);
    rows[4]  = makeRow({MEM_LOAD, MEM_STORE, MEM_LOAD, MEM_STORE}, 32'h0, 32'h55,
                       14, 14, 0, 0, 0, 0, 1, 0, 2, 2);
    rows[5]  = makeRow({MEM_LOAD, MEM_LOAD, MEM_NONE, MEM_LOAD}, 32'h0, 32'h66,
                       14, 0, 0, 0, 0, 0, 0, 1, 3, 0);
    rows[6]  = makeRow({MEM_NONE, MEM_NONE, MEM_NONE, MEM_NONE}, 32'h0, 32'h77,
                       0, 0, 28, 0, 0, 0, 1, 0, 0, 0);
    rows[7]  = makeRow({MEM_NONE, MEM_NONE, MEM_NONE, MEM_NONE}, 32'h0, 32'h88,
                       0, 0, 29, 0, 0, 0, 0, 1, 0, 0);
    rows[8]  = makeRow({MEM_LOAD, MEM_NONE, MEM_NONE, MEM_NONE}, 32'h0, 32'h99,
                       0, 0, 0, 60, 0, 0, 1, 0, 1, 0);
    rows[9]  = makeRow({MEM_NONE, MEM_NONE, MEM_NONE, MEM_NONE}, 32'h0, 32'haa,
                       0, 0, 0, 61, 0, 0, 0, 1, 0, 0);
    rows[10] = makeRow({MEM_LOAD, MEM_STORE, MEM_NONE, MEM_LOAD}, 32'hffffffff, 32'hbb,
                       3, 4, 5, 6, 1, 5, 1, 0, 2, 1);
    rows[11] = makeRow({MEM_STORE, MEM_NONE, MEM_LOAD, MEM_NONE}, 32'h81c3e7ff, 32'hcc,
                       0, 0, 0, 0, 1, 0, 1, 0, 1, 1);

    repeat (10) @(posedge clk);
    rstN_i <= 1'b1;
    @(negedge clk);
    assert (!backEndReady_o && !stallFrontEnd_o)
      else reportError("outputs not idle after reset");

    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      renamedBundle_i <= buildBundle(rows[i]);
      renameReady_i   <= 1'b1;
      queueCounts_i   <= '0;
      ctrlVerify_i    <= '0;
      bundleA = buildBundle(rows[i]);
      @(posedge clk);
      queueCounts_i   <= rows[i].counts;
      ctrlVerify_i    <= rows[i].verify;
      renameReady_i   <= 1'b0;
      @(negedge clk);
      checkOutputs(bundleA, rows[i].verify, rows[i].expReady, rows[i].expStall,
                   rows[i].expLoads, rows[i].expStores, $sformatf("row %0d", i));
    end

    // Stall holds bundle A with its freed mask bit while bundle B waits
    bundleA = buildBundle(rows[10]);
    bundleB = buildBundle(rows[11]);
    @(posedge clk);
    renamedBundle_i <= bundleA;
    renameReady_i   <= 1'b1;
    queueCounts_i   <= '0;
    ctrlVerify_i    <= '0;
    @(posedge clk);
    renamedBundle_i <= bundleB;
    queueCounts_i   <= '{loadQueueCnt: 5'd0, storeQueueCnt: 5'd0,
                         issueQueueCnt: 6'd29, activeListCnt: 7'd0};
    ctrlVerify_i    <= verifyTag2;
    @(negedge clk);
    checkOutputs(bundleA, verifyTag2, 1'b0, 1'b1, 2, 1, "stall start");
    @(posedge clk);
    ctrlVerify_i <= '0;
    @(negedge clk);
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      bundleA.inst[lane].branchMask[2] = 1'b0;
    end
    checkOutputs(bundleA, noVerify, 1'b0, 1'b1, 2, 1, "stall hold");
    @(posedge clk);
    queueCounts_i <= '0;
    @(posedge clk);
    renameReady_i <= 1'b0;
    @(negedge clk);
    checkOutputs(bundleB, noVerify, 1'b1, 1'b0, 1, 1, "after stall");

    // Recovery squashes the held bundle at once and wins over a capture at the edge
    @(posedge clk);
    renameReady_i   <= 1'b1;
    @(posedge clk);
    flagRecoverEX_i <= 1'b1;
    @(negedge clk);
    assert (!backEndReady_o) else reportError("backEndReady_o high during recovery");
    @(posedge clk);
    flagRecoverEX_i <= 1'b0;
    renameReady_i   <= 1'b0;
    @(negedge clk);
    assert (!backEndReady_o) else reportError("valid bit survived recovery");
    @(posedge clk);
    @(negedge clk);
    assert (!backEndReady_o) else reportError("valid bit set without capture");
    @(posedge clk);
    renameReady_i <= 1'b1;
    @(posedge clk);
    renameReady_i <= 1'b0;
    @(negedge clk);
    assert (backEndReady_o) else reportError("new capture after recovery not ready");

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* testbench/dispatch_assertions.sv */
//////////////////////////////
// Bound into dispatchTop, sees only its ports and the held bundle
//////////////////////////////

`timescale 1ns/100ps

module dispatchAssertions import dispatchPkg::*; (
  input logic           clk,
  input logic           rstN_i,
  input logic           backEndReady,
  input logic           stall,
  input renamedBundle_t heldBundle
);

  // Payload of a bundle with the valid bit and every branch mask zeroed
  function automatic renamedBundle_t payloadOnly(input renamedBundle_t b);
    renamedBundle_t p;
    p       = b;
    p.valid = 1'b0;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      p.inst[lane].branchMask = '0;
    end
    return p;
  endfunction

  // True when some lane has a mask bit set that was clear before
  function automatic logic maskBitSet(input renamedBundle_t cur, input renamedBundle_t prev);
    logic setBit;
    setBit = 1'b0;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      setBit = setBit | (|(cur.inst[lane].branchMask & ~prev.inst[lane].branchMask));
    end
    return setBit;
  endfunction

  // A stalled bundle must never be handed to the back end
  readyNotDuringStall: assert property (@(posedge clk) disable iff (!rstN_i)
    stall |-> !backEndReady)
    else $error("backEndReady_o high while stallFrontEnd_o is high");

  readyLowAfterReset: assert property (@(posedge clk)
    !rstN_i |=> !backEndReady)
    else $error("backEndReady_o high in the cycle after reset");

  // Only mask bits freed by a verified branch may change during a stall
  heldStableInStall: assert property (@(posedge clk) disable iff (!rstN_i)
    stall |=> payloadOnly(heldBundle) == payloadOnly($past(heldBundle)) &&
              !maskBitSet(heldBundle, $past(heldBundle)))
    else $error("held bundle changed during a stall");

endmodule
